//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = coreTb
FILELIST  = mipsCore.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/apbPort.sv
`timescale 1ns/1ps
`default_nettype none

module apbPort
    import isaPkg::*;
    import busPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  memReq_t req,
    output apbReq_t apb,
    input  apbRsp_t rsp,
    output logic    memDone,
    output word_t   rdata
);

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apbState_t;

    apbState_t state;
    logic      writeReg;
    word_t     addrReg, wdataReg;   // held from setup to completion
    logic      start, finish;

    // no restart while the requester still sees the previous completion
    assign start  = (state == idle) && req.valid && !memDone;
    assign finish = (state == access) && rsp.pready;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state    <= idle;
            writeReg <= 1'b0;
            memDone  <= 1'b0;
        end
        else
        begin
            memDone <= finish;      // one cycle pulse
            case (state)
                idle:
                begin
                    if (start)
                    begin
                        state    <= setup;
                        writeReg <= req.write;
                    end
                end
                setup:   state <= access;
                access:  if (finish) state <= idle;   // pready low stretches access
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            addrReg  <= req.addr;
            wdataReg <= req.wdata;
        end
        if (finish)
            rdata <= rsp.prdata;
    end

    always_comb
    begin
        apb.psel    = (state != idle);
        apb.penable = (state == access);
        apb.pwrite  = writeReg;
        apb.paddr   = addrReg;
        apb.pwdata  = wdataReg;
    end

endmodule

`default_nettype wire

//--- hdl/busPkg.sv
`default_nettype none

package busPkg;

    import isaPkg::*;

    // one request from the core, fetch or data
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;   // byte address
        word_t wdata;
    } memReq_t;

    // master side of the APB link
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apbReq_t;

    // slave side
    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apbRsp_t;

endpackage

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    input  funct_t  funct,
    input  logic    zero,
    input  logic    memDone,
    output ctrl_t   ctrl,
    output logic    memValid,
    output logic    memWrite,
    output logic    dataAccess
);

    typedef enum logic [3:0] {
        fetch,
        decode,
        execute,
        writeBack,
        effAddr,
        loadMem,
        loadWrite,
        storeMem,
        branchCmp
    } cuState_t;

    cuState_t state, nextState;
    ctrl_t    ctrlReg, nextCtrl;
    aluOp_t   functOp;     // alu op for an R-type instruction

    always_comb
    begin
        case (funct)
            functAdd: functOp = aluAdd;
            functSub: functOp = aluSub;
            functAnd: functOp = aluAnd;
            functOr:  functOp = aluOr;
            functSlt: functOp = aluSlt;
            default:  functOp = aluAdd;
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            fetch:     if (memDone) nextState = decode;   // wait for the instruction word
            decode:
            begin
                case (opcode)
                    rType:   nextState = execute;
                    lw, sw:  nextState = effAddr;
                    beq:     nextState = branchCmp;
                    default: nextState = fetch;           // not in the subset
                endcase
            end
            execute:   nextState = writeBack;
            writeBack: nextState = fetch;
            effAddr:   nextState = (opcode == lw) ? loadMem : storeMem;
            loadMem:   if (memDone) nextState = loadWrite;
            loadWrite: nextState = fetch;
            storeMem:  if (memDone) nextState = fetch;
            branchCmp: nextState = fetch;
            default:   nextState = fetch;
        endcase
    end

    // control word of the state being entered, registered with the state
    always_comb
    begin
        nextCtrl = '0;
        case (nextState)
            fetch:
            begin
                nextCtrl.pcWrite = 1'b1;
                nextCtrl.irWrite = 1'b1;
                nextCtrl.aluSrcB = constFour;  // pc + 4
            end
            decode:
            begin
                // read rs/rt and precompute the beq target from pc + 4
                nextCtrl.operandLatch = 1'b1;
                nextCtrl.aluOutLatch  = 1'b1;
                nextCtrl.aluSrcB      = shiftedImm;
            end
            execute:
            begin
                nextCtrl.aluSrcA     = 1'b1;
                nextCtrl.aluSrcB     = regB;
                nextCtrl.aluOp       = functOp;
                nextCtrl.aluOutLatch = 1'b1;
            end
            writeBack:
            begin
                nextCtrl.regWrite = 1'b1;
                nextCtrl.regDstRd = 1'b1;    // R-type writes rd
            end
            effAddr:
            begin
                nextCtrl.aluSrcA     = 1'b1;  // base + offset
                nextCtrl.aluSrcB     = signExtImm;
                nextCtrl.aluOutLatch = 1'b1;
            end
            loadMem:   nextCtrl.mdrLatch = 1'b1;
            loadWrite:
            begin
                nextCtrl.regWrite = 1'b1;    // into rt
                nextCtrl.memToReg = 1'b1;
            end
            branchCmp:
            begin
                nextCtrl.branch       = 1'b1;
                nextCtrl.pcFromAluOut = 1'b1;  // target latched in decode
            end
            default:   nextCtrl = '0;          // storeMem needs no datapath enables
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state   <= fetch;
            ctrlReg <= '0;    // loads the fetch word on the first edge
        end
        else
        begin
            state   <= nextState;
            ctrlReg <= nextCtrl;
        end
    end

    // branch only taken on equal operands
    always_comb
    begin
        ctrl        = ctrlReg;
        ctrl.branch = ctrlReg.branch & zero;
    end

    assign memValid   = (state == fetch) || (state == loadMem) || (state == storeMem);
    assign memWrite   = (state == storeMem);
    assign dataAccess = (state == loadMem) || (state == storeMem);  // address from aluOut

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    input  logic    dataAccess,
    input  logic    memDone,
    input  word_t   rdata,
    output opcode_t opcode,
    output funct_t  funct,
    output logic    zero,
    output word_t   reqAddr,
    output word_t   reqWdata
);

    instr_t   ir;
    word_t    pc;
    word_t    regFile [regCount];
    word_t    aReg, bReg;        // operand registers
    word_t    aluOut, mdr;
    word_t    srcA, srcB, aluResult;
    word_t    immExt, pcNext, wbData;
    imm_t     imm;
    regAddr_t wbAddr;
    logic     pcEn;

    assign opcode = ir.opcode;
    assign funct  = ir.funct;
    assign imm    = ir[immWidth-1:0];
    assign immExt = {{(wordWidth-immWidth){imm[immWidth-1]}}, imm};  // sign extend

    assign srcA = ctrl.aluSrcA ? aReg : pc;

    always_comb
    begin
        case (ctrl.aluSrcB)
            regB:       srcB = bReg;
            constFour:  srcB = word_t'(4);
            signExtImm: srcB = immExt;
            default:    srcB = immExt << 2;   // word offset to bytes
        endcase
    end

    always_comb
    begin
        case (ctrl.aluOp)
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSlt:  aluResult = ($signed(srcA) < $signed(srcB)) ? word_t'(1) : '0;
            default: aluResult = srcA + srcB;
        endcase
    end

    // beq condition straight from the operand registers, same as A - B == 0
    assign zero = (aReg == bReg);

    // pc + 4 at fetch completion, latched target on a taken branch
    assign pcEn   = (ctrl.pcWrite && memDone) || ctrl.branch;
    assign pcNext = ctrl.pcFromAluOut ? aluOut : aluResult;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            pc <= '0;
            ir <= '0;
        end
        else
        begin
            if (pcEn)
                pc <= pcNext;
            if (ctrl.irWrite && memDone)
                ir <= instr_t'(rdata);
        end
    end

    assign wbAddr = ctrl.regDstRd ? ir.rd : ir.rt;
    assign wbData = ctrl.memToReg ? mdr : aluOut;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < regCount; i++)
                regFile[i] <= '0;
        end
        else if (ctrl.regWrite && (wbAddr != '0))   // r0 stays zero
        begin
            regFile[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.operandLatch)
        begin
            aReg <= regFile[ir.rs];
            bReg <= regFile[ir.rt];
        end
        if (ctrl.aluOutLatch)
            aluOut <= aluResult;
        if (ctrl.mdrLatch && memDone)
            mdr <= rdata;     // load data
    end

    assign reqAddr  = dataAccess ? aluOut : pc;
    assign reqWdata = bReg;   // sw stores rt

endmodule

`default_nettype wire

//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 1 << regAddrWidth;   // 32 gp registers
    localparam int immWidth     = 16;
    localparam int shamtWidth   = 5;

    typedef logic [wordWidth-1:0]    word_t;       // data word or byte address
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [immWidth-1:0]     imm_t;        // raw I-type immediate
    typedef logic [shamtWidth-1:0]   shamt_t;      // not used by the subset

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        rType = 6'h00,
        beq   = 6'h04,
        lw    = 6'h23,
        sw    = 6'h2b
    } opcode_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        functAdd = 6'h20,
        functSub = 6'h22,
        functAnd = 6'h24,
        functOr  = 6'h25,
        functSlt = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,  // zero value, so an idle word adds
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluSlt = 4'd4   // signed compare
    } aluOp_t;

    typedef enum logic [1:0] {
        regB       = 2'd0,
        constFour  = 2'd1,  // pc + 4
        signExtImm = 2'd2,  // lw/sw offset
        shiftedImm = 2'd3   // beq word offset
    } srcBSel_t;

    // R-type view of an instruction word; I-type immediate is bits 15:0
    typedef struct packed {
        opcode_t  opcode;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        shamt_t   shamt;
        funct_t   funct;
    } instr_t;

    typedef struct packed {
        logic     pcWrite;       // pc <= pc + 4 when the fetch completes
        logic     branch;        // pc <= target, only meaningful with zero
        logic     pcFromAluOut;  // pc source: 1 = aluOut, 0 = live alu result
        logic     irWrite;
        logic     operandLatch;  // A and B from the register file
        logic     aluOutLatch;
        logic     mdrLatch;
        logic     regWrite;
        logic     regDstRd;      // 1 = rd, 0 = rt
        logic     memToReg;      // writeback source: 1 = mdr
        logic     aluSrcA;       // 1 = A, 0 = pc
        srcBSel_t aluSrcB;
        aluOp_t   aluOp;
    } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import isaPkg::*;
    import busPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output apbReq_t apb,
    input  apbRsp_t rsp
);

    ctrl_t   ctrl;
    opcode_t opcode;
    funct_t  funct;
    logic    zero;
    logic    memValid, memWrite, dataAccess, memDone;
    word_t   rdata, reqAddr, reqWdata;
    memReq_t req;

    // fetch and data share the one port
    assign req = '{valid: memValid, write: memWrite, addr: reqAddr, wdata: reqWdata};

    controlUnit controlUnit
    (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .zero       (zero),
        .memDone    (memDone),
        .ctrl       (ctrl),
        .memValid   (memValid),
        .memWrite   (memWrite),
        .dataAccess (dataAccess)
    );

    datapath datapath
    (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .dataAccess (dataAccess),
        .memDone    (memDone),
        .rdata      (rdata),
        .opcode     (opcode),
        .funct      (funct),
        .zero       (zero),
        .reqAddr    (reqAddr),
        .reqWdata   (reqWdata)
    );

    apbPort apbPort
    (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .apb     (apb),
        .rsp     (rsp),
        .memDone (memDone),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

//--- mipsCore.f
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/apbPort.sv
hdl/mipsCore.sv
verification/storeChecker.sv
verification/coreTb.sv

//--- verification/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

    import isaPkg::*;
    import busPkg::*;

    localparam int memWords = 256;   // 1 KiB unified memory
    localparam int worstCpi = 17;    // lw with 3 wait states on fetch and on load
    localparam int margin   = 20;    // extra instructions before the watchdog fires

    logic        clk   = 1'b0;
    logic        reset = 1'b0;
    apbRsp_t     rsp   = '0;
    apbReq_t     apb;
    word_t       progImage [memWords];
    word_t       mem [memWords];
    logic [1:0]  waitCnt;
    logic [31:0] lfsr = 32'hcf639056;
    logic        done;
    int          expInstrs, checkCount, errorCount;

    function automatic word_t encodeR(input funct_t fn, input int rs, input int rt, input int rd);
        return {rType, regAddr_t'(rs), regAddr_t'(rt), regAddr_t'(rd), 5'd0, fn};
    endfunction

    function automatic word_t encodeI(input opcode_t op, input int rs, input int rt,
                                      input int imm);
        return {op, regAddr_t'(rs), regAddr_t'(rt), imm_t'(imm)};
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic printCounts();
        $display("checks %0d, errors %0d", checkCount, errorCount);
    endtask

    mipsCore dut
    (
        .clk   (clk),
        .reset (reset),
        .apb   (apb),
        .rsp   (rsp)
    );

    storeChecker #(.memWords(memWords)) scoreboard
    (
        .clk        (clk),
        .reset      (reset),
        .apb        (apb),
        .rsp        (rsp),
        .image      (progImage),
        .expInstrs  (expInstrs),
        .checkCount (checkCount),
        .errorCount (errorCount),
        .done       (done)
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    initial
    begin
        foreach (progImage[i])
            progImage[i] = 32'hbad0_0000 ^ (word_t'(i) << 2);   // address dependent filler
        progImage[0]  = encodeI(lw, 0, 1, 'h100);        // r1 = 7
        progImage[1]  = encodeI(lw, 0, 2, 'h104);        // r2 = -11
        progImage[2]  = encodeR(functAdd, 1, 2, 3);
        progImage[3]  = encodeI(sw, 0, 3, 'h140);
        progImage[4]  = encodeR(functSub, 1, 2, 4);
        progImage[5]  = encodeI(sw, 0, 4, 'h144);
        progImage[6]  = encodeR(functAnd, 1, 2, 5);
        progImage[7]  = encodeI(sw, 0, 5, 'h148);
        progImage[8]  = encodeR(functOr, 1, 2, 6);
        progImage[9]  = encodeI(sw, 0, 6, 'h14c);
        progImage[10] = encodeR(functSlt, 2, 1, 7);      // -11 < 7
        progImage[11] = encodeI(sw, 0, 7, 'h150);
        progImage[12] = encodeR(functSlt, 1, 2, 8);
        progImage[13] = encodeI(sw, 0, 8, 'h154);
        progImage[14] = encodeI(lw, 0, 9, 'h108);
        progImage[15] = encodeI(lw, 0, 10, 'h10c);       // base 0x160
        progImage[16] = encodeI(sw, 10, 9, -8);          // negative offset
        progImage[17] = encodeI(lw, 10, 11, -8);
        progImage[18] = encodeI(sw, 10, 11, 4);
        progImage[19] = encodeR(functAdd, 1, 1, 0);      // r0 target is ignored
        progImage[20] = encodeI(lw, 0, 0, 'h100);
        progImage[21] = encodeI(sw, 0, 0, 'h168);        // must store zero
        progImage[22] = encodeI(beq, 1, 2, 1);           // not taken
        progImage[23] = encodeI(sw, 0, 1, 'h16c);
        progImage[24] = encodeI(beq, 1, 1, 1);           // taken so the next store is skipped
        progImage[25] = encodeI(sw, 0, 2, 'h170);
        progImage[26] = encodeI(sw, 0, 3, 'h174);
        progImage[27] = 32'hfc00_0000;                   // opcode outside the subset
        progImage[28] = encodeI(sw, 0, 4, 'h178);
        progImage[29] = encodeI(beq, 0, 0, -1);          // halt loop
        progImage[64] = 32'h0000_0007;
        progImage[65] = 32'hffff_fff5;
        progImage[66] = 32'h1234_5678;
        progImage[67] = 32'h0000_0160;
    end

    // APB slave memory with 0 to 3 wait states per access
    always @(posedge clk)
    begin
        logic [31:0] s;
        logic [1:0]  waits;
        if (!reset)
        begin
            rsp     <= '0;
            waitCnt <= '0;
            mem     <= progImage;
        end
        else
        begin
            rsp.prdata <= mem[apb.paddr[9:2]];
            if (apb.psel && !apb.penable)
            begin
                s          = lfsr;
                waits[0]   = s[0];
                s          = lfsrStep(s);
                waits[1]   = s[0];
                s          = lfsrStep(s);
                lfsr       <= s;
                waitCnt    <= waits;
                rsp.pready <= (waits == 2'd0);
            end
            else if (apb.psel && apb.penable && !rsp.pready)
            begin
                waitCnt    <= waitCnt - 2'd1;
                rsp.pready <= (waitCnt == 2'd1);   // last wait cycle
            end
            else
            begin
                rsp.pready <= 1'b0;
                if (apb.psel && apb.penable && apb.pwrite)
                    mem[apb.paddr[9:2]] <= apb.pwdata;
            end
        end
    end

    initial
    begin
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        wait (done === 1'b1);
        printCounts();
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // bound from the reference instruction count
    initial
    begin
        @(posedge reset);
        @(posedge clk);
        repeat ((expInstrs + margin) * worstCpi) @(posedge clk);
        $display("watchdog: the core did not reach its halt loop in time");
        printCounts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/storeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module storeChecker
    import isaPkg::*;
    import busPkg::*;
#(
    parameter int memWords = 256
)
(
    input  logic    clk,
    input  logic    reset,
    input  apbReq_t apb,
    input  apbRsp_t rsp,
    input  word_t   image [memWords],  // program and data as loaded at reset
    output int      expInstrs,
    output int      checkCount,
    output int      errorCount,
    output logic    done
);

    localparam int maxSteps = 1000;   // guards the model against a runaway program

    word_t   expAddr [$];   // expected stores, in program order
    word_t   expData [$];
    word_t   haltPc = '1;   // address of the beq that jumps to itself
    apbReq_t setupReq;      // transfer as seen in its setup phase
    logic    prevPsel, prevPenable, prevReady;
    logic    seenFirst;
    int      storeIdx;

    function automatic int wordIndex(input word_t addr);
        return int'(addr >> 2) % memWords;
    endfunction

    // instruction-set model of the subset, fills expAddr/expData
    function automatic int runReference();
        word_t regs [regCount];
        word_t dmem [memWords];
        word_t pc, curPc, instr, a, b, imm, res;
        int    count;
        foreach (regs[i])
            regs[i] = '0;
        dmem  = image;
        pc    = '0;
        count = 0;
        expAddr.delete();
        expData.delete();
        for (int step = 0; step < maxSteps; step++)
        begin
            curPc = pc;
            instr = dmem[wordIndex(pc)];
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            imm   = {{16{instr[15]}}, instr[15:0]};
            pc    = pc + 32'd4;
            count++;
            case (instr[31:26])
                rType:
                begin
                    case (instr[5:0])
                        functSub: res = a - b;
                        functAnd: res = a & b;
                        functOr:  res = a | b;
                        functSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  res = a + b;
                    endcase
                    if (instr[15:11] != 5'd0)
                        regs[instr[15:11]] = res;   // rd
                end
                lw:
                begin
                    if (instr[20:16] != 5'd0)
                        regs[instr[20:16]] = dmem[wordIndex(a + imm)];
                end
                sw:
                begin
                    dmem[wordIndex(a + imm)] = b;
                    expAddr.push_back(a + imm);
                    expData.push_back(b);
                end
                beq:     if (a == b) pc = pc + (imm << 2);  // relative to pc + 4
                default: ;                                   // unknown opcode, no effect
            endcase
            if (pc == curPc)
            begin
                haltPc = curPc;
                return count;
            end
        end
        $display("reference model ran %0d instructions without a halt loop", maxSteps);
        return maxSteps;
    endfunction

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportFault(input string what);
        errorCount++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    initial
    begin
        @(posedge reset);
        expInstrs = runReference();
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (apb.psel || apb.penable)
                reportFault("psel or penable high during reset");
            prevPsel    <= 1'b0;
            prevPenable <= 1'b0;
            prevReady   <= 1'b0;
            seenFirst   <= 1'b0;
            storeIdx    <= 0;
            done        <= 1'b0;
        end
        else
        begin
            prevPsel    <= apb.psel;
            prevPenable <= apb.penable;
            prevReady   <= rsp.pready;
            if (apb.penable && !apb.psel)
                reportFault("penable high without psel");
            if (apb.psel && !apb.penable)
            begin
                if (prevPsel && !prevPenable)
                    reportFault("setup phase longer than one cycle");
                setupReq <= apb;
            end
            if (apb.psel && apb.penable)
            begin
                if (!prevPenable && !prevPsel)
                    reportFault("penable rose together with psel");
                if (prevPenable && prevReady)
                    reportFault("access phase without a setup phase");
                if (apb.pwrite != setupReq.pwrite)
                    reportFault("pwrite changed during the transfer");
                compareWord("paddr hold", setupReq.paddr, apb.paddr);
                if (apb.pwrite)
                    compareWord("pwdata hold", setupReq.pwdata, apb.pwdata);
                if (rsp.pready)   // transfer completes on this edge
                begin
                    if (!seenFirst)
                    begin
                        seenFirst <= 1'b1;
                        compareWord("first transfer addr", 32'h0, apb.paddr);
                        if (apb.pwrite)
                            reportFault("first transfer after reset is a write");
                    end
                    if (apb.pwrite)
                    begin
                        if (storeIdx < expAddr.size())
                        begin
                            compareWord($sformatf("store %0d addr", storeIdx),
                                        expAddr[storeIdx], apb.paddr);
                            compareWord($sformatf("store %0d data", storeIdx),
                                        expData[storeIdx], apb.pwdata);
                        end
                        else
                            reportFault("store beyond the expected list");
                        storeIdx <= storeIdx + 1;
                    end
                    else if (apb.paddr == haltPc && !done)
                    begin
                        if (storeIdx != expAddr.size())
                            reportFault($sformatf("halt reached after %0d of %0d stores",
                                                  storeIdx, expAddr.size()));
                        done <= 1'b1;   // fetch of the halt loop
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
